// ==== all.f ====
hw/ps2_pkg.sv
hw/byte_fifo.sv
hw/ps2_send.sv
hw/ps2_axil_regs.sv
hw/ps2_kbd_top.sv
tb/ps2_host_model.sv
tb/ps2_kbd_tb.sv

// ==== hw/byte_fifo.sv ====
// Synchronous FIFO of scancode bytes.
// Circular buffer with read and write pointers and a fill count.
`timescale 1ns/1ps

module byte_fifo import ps2_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  push,
   input  logic [7:0]            push_data,
   input  logic                  pop,
   output logic [7:0]            head_data,
   output logic                  empty,
   output logic                  full,
   output logic [FIFO_CNT_W-1:0] count
);

   logic [7:0]            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic                  wr_en;
   logic                  rd_en;

   assign empty     = (count == '0);
   assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
   assign head_data = mem[rd_ptr];

   assign rd_en = pop && !empty;
   assign wr_en = push && (!full || rd_en);           // Pop frees a slot this cycle.

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                                // Both or neither, no change.
         endcase
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      pop |-> !empty)
      else $error("pop from an empty FIFO");

   a_count_range: assert property (@(posedge clk) disable iff (reset)
      count <= FIFO_CNT_W'(FIFO_DEPTH))
      else $error("FIFO count above depth");

endmodule

// ==== hw/ps2_axil_regs.sv ====
// AXI4-Lite slave for the PS/2 transmitter.
// TXDATA pushes bytes into the FIFO, STATUS reports FIFO and sender
// state with a sticky overflow flag, CTRL holds the send enable.
`timescale 1ns/1ps

module ps2_axil_regs import ps2_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   // Write address.
   input  logic [AXI_ADDR_W-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   // Write data.
   input  logic [AXI_DATA_W-1:0] wdata,
   input  logic [3:0]            wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   // Write response.
   output logic [1:0]            bresp,
   output logic                  bvalid,
   input  logic                  bready,
   // Read address.
   input  logic [AXI_ADDR_W-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   // Read data.
   output logic [AXI_DATA_W-1:0] rdata,
   output logic [1:0]            rresp,
   output logic                  rvalid,
   input  logic                  rready,
   // FIFO and sender side.
   input  logic                  full,
   input  logic                  empty,
   input  logic [FIFO_CNT_W-1:0] count,
   input  logic                  busy,
   output logic                  push,
   output logic [7:0]            push_data,
   output logic                  enable
);

   logic                  wr_go;
   logic                  rd_go;
   logic                  wr_hit;
   logic                  lane0;
   logic                  wr_txdata;
   logic                  wr_status;
   logic                  wr_ctrl;
   logic                  overflow;
   logic [AXI_DATA_W-1:0] status_word;

   // One write and one read may be in flight.
   assign wr_go   = awvalid && wvalid && !bvalid;
   assign rd_go   = arvalid && !rvalid;
   assign awready = wr_go;
   assign wready  = wr_go;
   assign arready = !rvalid;

   assign lane0     = wstrb[0];                       // Only byte lane 0 carries data.
   assign wr_txdata = wr_go && lane0 && (awaddr == ADDR_TXDATA);
   assign wr_status = wr_go && lane0 && (awaddr == ADDR_STATUS);
   assign wr_ctrl   = wr_go && lane0 && (awaddr == ADDR_CTRL);
   assign wr_hit    = (awaddr == ADDR_TXDATA) || (awaddr == ADDR_STATUS) ||
                      (awaddr == ADDR_CTRL);

   // A byte aimed at a full FIFO is dropped.
   assign push      = wr_txdata && !full;
   assign push_data = wdata[7:0];

   always_comb begin
      status_word                                = '0;
      status_word[ST_EMPTY]                      = empty;
      status_word[ST_FULL]                       = full;
      status_word[ST_BUSY]                       = busy;
      status_word[ST_OVERFLOW]                   = overflow;
      status_word[ST_COUNT_LSB +: FIFO_CNT_W]    = count;
   end

   // Write response channel.
   always_ff @(posedge clk) begin
      if (reset) begin
         bvalid <= 1'b0;
         bresp  <= RESP_OKAY;
      end else if (wr_go) begin
         bvalid <= 1'b1;
         bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   // Sticky overflow and the enable bit.
   always_ff @(posedge clk) begin
      if (reset) begin
         overflow <= 1'b0;
         enable   <= 1'b0;
      end else begin
         if (wr_txdata && full)
            overflow <= 1'b1;
         else if (wr_status && wdata[ST_OVERFLOW])
            overflow <= 1'b0;                         // Write 1 to clear.
         if (wr_ctrl)
            enable <= wdata[CTRL_ENABLE];
      end
   end

   // Read data channel.
   always_ff @(posedge clk) begin
      if (reset)
         rvalid <= 1'b0;
      else if (rd_go)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (rd_go) begin
         rresp <= RESP_OKAY;
         rdata <= '0;                                 // TXDATA reads as zero.
         case (araddr)
            ADDR_TXDATA: ;
            ADDR_STATUS: rdata <= status_word;
            ADDR_CTRL:   rdata[CTRL_ENABLE] <= enable;
            default:     rresp <= RESP_SLVERR;
         endcase
      end
   end

   // Responses hold until the master takes them.
   a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid dropped before bready");

   a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("rvalid dropped before rready");

   // A pushed byte shows in the FIFO on the next cycle.
   a_push_lands: assert property (@(posedge clk) disable iff (reset)
      push |=> !empty)
      else $error("pushed byte missing from the FIFO");

endmodule

// ==== hw/ps2_kbd_top.sv ====
// PS/2 keyboard transmitter top level.
// AXI4-Lite registers feed a byte FIFO that drains into the PS/2 sender.
`timescale 1ns/1ps

module ps2_kbd_top import ps2_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [AXI_ADDR_W-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [AXI_DATA_W-1:0] wdata,
   input  logic [3:0]            wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   output logic [1:0]            bresp,
   output logic                  bvalid,
   input  logic                  bready,
   input  logic [AXI_ADDR_W-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output logic [AXI_DATA_W-1:0] rdata,
   output logic [1:0]            rresp,
   output logic                  rvalid,
   input  logic                  rready,
   output logic                  ps2_clk,
   output logic                  ps2_data
);

   logic                  push;
   logic [7:0]            push_data;
   logic                  full;
   logic                  empty;
   logic [FIFO_CNT_W-1:0] count;
   logic [7:0]            head_data;
   logic                  code_ready;
   logic                  take;
   logic                  busy;
   logic                  enable;

   assign code_ready = ~empty;

   ps2_axil_regs regs_inst (
      .*
   );

   byte_fifo fifo_inst (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (take),                              // Sender pops as it starts a frame.
      .head_data (head_data),
      .empty     (empty),
      .full      (full),
      .count     (count)
   );

   ps2_send send_inst (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .code       (head_data),
      .code_ready (code_ready),
      .take       (take),
      .busy       (busy),
      .ps2_clk    (ps2_clk),
      .ps2_data   (ps2_data)
   );

endmodule

// ==== hw/ps2_pkg.sv ====
// Shared constants for the PS/2 keyboard transmitter.
// Covers the AXI4-Lite register map and response codes, FIFO sizing,
// PS/2 bit timing and the status and control bit positions.
package ps2_pkg;

   // PS/2 bit timing, in clk cycles.
   localparam int HALF_BIT_CYCLES = 4;      // Sim value; real use is f_clk / 20 kHz.
   localparam int FRAME_BITS      = 11;     // Start, 8 data, parity, stop.
   localparam int FRAME_STEPS     = 2 * FRAME_BITS;
   localparam int STEP_W          = $clog2(FRAME_STEPS + 1);
   localparam int HALF_CNT_W      = (HALF_BIT_CYCLES > 1) ? $clog2(HALF_BIT_CYCLES) : 1;

   // Scancode FIFO.
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // AXI4-Lite bus.
   localparam int AXI_ADDR_W = 4;
   localparam int AXI_DATA_W = 32;

   localparam logic [AXI_ADDR_W-1:0] ADDR_TXDATA = 4'h0;
   localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = 4'h4;
   localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL   = 4'h8;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // STATUS register fields.
   localparam int ST_EMPTY     = 0;
   localparam int ST_FULL      = 1;
   localparam int ST_BUSY      = 2;
   localparam int ST_OVERFLOW  = 3;
   localparam int ST_COUNT_LSB = 8;

   // CTRL register fields.
   localparam int CTRL_ENABLE = 0;

endpackage

// ==== hw/ps2_send.sv ====
// PS/2 frame sender, keyboard side.
// Shifts start, 8 data bits LSB first, odd parity and stop onto the
// PS/2 data line while generating the PS/2 clock.
`timescale 1ns/1ps

module ps2_send import ps2_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       enable,
   input  logic [7:0] code,
   input  logic       code_ready,
   output logic       take,
   output logic       busy,
   output logic       ps2_clk,
   output logic       ps2_data
);

   // Half-bit steps count down from FRAME_STEPS to 1; even steps are
   // the high half of a bit, odd steps the low half. Zero is idle.
   logic [STEP_W-1:0]     step;
   logic [HALF_CNT_W-1:0] half_cnt;
   logic [FRAME_BITS-1:0] shreg;
   logic                  half_done;
   logic                  parity;

   assign half_done = (half_cnt == '0);
   assign parity    = ~^code;                         // Odd parity.
   assign take      = !busy && enable && code_ready;

   assign ps2_clk  = ~step[0];
   assign ps2_data = busy ? shreg[0] : 1'b1;

   always_ff @(posedge clk) begin
      if (reset) begin
         step     <= '0;
         half_cnt <= '0;
         busy     <= 1'b0;
      end else if (take) begin
         step     <= STEP_W'(FRAME_STEPS);
         half_cnt <= HALF_CNT_W'(HALF_BIT_CYCLES - 1);
         busy     <= 1'b1;
      end else if (busy && half_done) begin
         step     <= step - 1'b1;
         half_cnt <= HALF_CNT_W'(HALF_BIT_CYCLES - 1);
         if (step == STEP_W'(1))
            busy <= 1'b0;                             // Last low half done.
      end else if (busy) begin
         half_cnt <= half_cnt - 1'b1;
      end
   end

   // Next bit appears as the clock goes high.
   always_ff @(posedge clk) begin
      if (take)
         shreg <= {1'b1, parity, code, 1'b0};
      else if (busy && half_done && step[0])
         shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
   end

   // The host samples on the falling edge, so data holds through the low half.
   a_data_stable_low: assert property (@(posedge clk) disable iff (reset)
      !ps2_clk && ($past(ps2_clk) == 1'b0) |-> $stable(ps2_data))
      else $error("ps2_data changed while ps2_clk low");

   a_busy_step: assert property (@(posedge clk) disable iff (reset)
      busy |-> step != '0)
      else $error("busy with idle step count");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the PS/2 transmitter testbench with Verilator.
# The simulator's exit status decides pass or fail.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module ps2_kbd_tb \
   -Mdir obj_dir -o ps2_kbd_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/ps2_kbd_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

// ==== tb/ps2_host_model.sv ====
// PS/2 host model for the testbench.
// Watches the PS/2 lines mid-cycle, rebuilds each 11-bit frame and
// reports the byte, its framing result and the frame length.
`timescale 1ns/1ps

module ps2_host_model import ps2_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        ps2_clk,
   input  logic        ps2_data,
   output logic        rx_valid,
   output logic [7:0]  rx_byte,
   output logic        frame_ok,
   output logic [15:0] frame_cycles
);

   logic                  clk_q;
   logic [3:0]            nbits;
   logic [15:0]           cyc;
   logic [FRAME_BITS-1:0] bits;

   // Lines change just after the rising clk edge, so the falling edge sees them settled.
   always @(negedge clk) begin
      rx_valid <= 1'b0;
      if (reset) begin
         clk_q        <= 1'b1;
         nbits        <= '0;
         cyc          <= '0;
         bits         <= '0;
         rx_byte      <= '0;
         frame_ok     <= 1'b0;
         frame_cycles <= '0;
      end else begin
         clk_q <= ps2_clk;
         if (nbits != 4'd0)
            cyc <= cyc + 16'd1;                       // Length of the frame so far.
         if (clk_q && !ps2_clk) begin
            bits[nbits] <= ps2_data;                  // Sample on the falling PS/2 clock.
            nbits       <= nbits + 4'd1;
            if (nbits == 4'd0)
               cyc <= '0;
         end else if (!clk_q && ps2_clk && nbits == 4'(FRAME_BITS)) begin
            // Clock back high after the stop bit ends the frame.
            rx_valid     <= 1'b1;
            rx_byte      <= bits[8:1];
            frame_ok     <= (bits[0] == 1'b0) && (bits[FRAME_BITS-1] == 1'b1) &&
                            (^bits[FRAME_BITS-2:1] == 1'b1);
            frame_cycles <= cyc + 16'd1;
            nbits        <= '0;
         end
      end
   end

endmodule

// ==== tb/ps2_kbd_tb.sv ====
// Testbench for the PS/2 keyboard transmitter.
// AXI4-Lite tasks, status checks, an expected byte store checked against
// the host model, and a cycle limit on the whole run.
`timescale 1ns/1ps

module ps2_kbd_tb import ps2_pkg::*; ();

   localparam int FRAME_CYCLES   = 2 * FRAME_BITS * HALF_BIT_CYCLES;
   localparam int FALL_TO_END    = FRAME_CYCLES - HALF_BIT_CYCLES;  // First half bit is high.
   localparam int FIRST_FALL_MAX = 2 + HALF_BIT_CYCLES;
   localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES + 2000;
   localparam int STREAM_BYTES   = 24;
   localparam int TOTAL_BYTES    = 1 + FIFO_DEPTH + STREAM_BYTES;
   localparam logic [AXI_ADDR_W-1:0] ADDR_BAD = 4'hC;

   logic                  clk;
   logic                  reset;
   logic [AXI_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   logic [AXI_DATA_W-1:0] wdata;
   logic [3:0]            wstrb;
   logic                  wvalid;
   logic                  wready;
   logic [1:0]            bresp;
   logic                  bvalid;
   logic                  bready;
   logic [AXI_ADDR_W-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic [AXI_DATA_W-1:0] rdata;
   logic [1:0]            rresp;
   logic                  rvalid;
   logic                  rready;
   logic                  ps2_clk;
   logic                  ps2_data;
   logic                  rx_valid;
   logic [7:0]            rx_byte;
   logic                  frame_ok;
   logic [15:0]           frame_cycles;
   int                    cycle;
   int                    accept_cyc;
   int                    rx_total;
   logic [31:0]           rand_state;
   logic [7:0]            exp_mem [64];
   logic [5:0]            exp_wr;
   logic [5:0]            exp_rd;

   ps2_kbd_top ps2_kbd_top_inst (.*);

   ps2_host_model host_inst (
      .clk          (clk),
      .reset        (reset),
      .ps2_clk      (ps2_clk),
      .ps2_data     (ps2_data),
      .rx_valid     (rx_valid),
      .rx_byte      (rx_byte),
      .frame_ok     (frame_ok),
      .frame_cycles (frame_cycles)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] got);
      stop_on_error($sformatf("MISMATCH at %0t: %s, expected %0d, got %0d",
                              $time, what, exp, got));
   endtask

   task automatic expect_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else report_mismatch(what, exp, got);
   endtask

   // Advances the LCG and returns bits 23:16 of the new state.
   function automatic logic [7:0] rand_byte();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state[23:16];
   endfunction

   task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'hF;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      awvalid    = 1'b0;
      wvalid     = 1'b0;
      accept_cyc = cycle;                             // Cycle of the accepting edge.
      resp       = bresp;
   endtask

   task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      arvalid = 1'b0;
      data    = rdata;
      resp    = rresp;
   endtask

   task automatic check_status(input logic exp_empty, input logic exp_full,
                               input logic exp_busy, input logic exp_ovf, input int exp_count);
      logic [31:0] val;
      logic [1:0]  resp;
      axi_read(ADDR_STATUS, val, resp);
      expect_eq("STATUS rresp", 32'(resp), 32'(RESP_OKAY));
      expect_eq("STATUS empty", 32'(val[ST_EMPTY]), 32'(exp_empty));
      expect_eq("STATUS full", 32'(val[ST_FULL]), 32'(exp_full));
      expect_eq("STATUS busy", 32'(val[ST_BUSY]), 32'(exp_busy));
      expect_eq("STATUS overflow", 32'(val[ST_OVERFLOW]), 32'(exp_ovf));
      expect_eq("STATUS count", 32'(val[ST_COUNT_LSB +: FIFO_CNT_W]), 32'(exp_count));
   endtask

   task automatic push_byte(input logic [7:0] b);
      logic [1:0] resp;
      axi_write(ADDR_TXDATA, {24'd0, b}, resp);
      expect_eq("TXDATA bresp", 32'(resp), 32'(RESP_OKAY));
      exp_mem[exp_wr] = b;
      exp_wr          = exp_wr + 6'd1;
   endtask

   task automatic wait_drained();
      while (exp_rd != exp_wr) @(negedge clk);
   endtask

   // Scoreboard for bytes rebuilt by the host.
   always @(negedge clk) begin
      if (reset) begin
         exp_rd   <= '0;
         rx_total <= 0;
      end else if (rx_valid) begin
         assert (exp_rd != exp_wr) else stop_on_error("Host received a byte that was never sent");
         expect_eq("received byte", 32'(rx_byte), 32'(exp_mem[exp_rd]));
         exp_rd   <= exp_rd + 6'd1;
         rx_total <= rx_total + 1;
      end
   end

   a_frame_ok: assert property (@(negedge clk) disable iff (reset) rx_valid |-> frame_ok)
      else stop_on_error("Host saw a frame with a bad start bit, stop bit or parity");

   a_frame_len: assert property (@(negedge clk) disable iff (reset)
      rx_valid |-> frame_cycles == 16'(FALL_TO_END))
      else report_mismatch("cycles from first fall to frame end", 32'(FALL_TO_END),
                           32'(frame_cycles));

   // Address and data are taken together when no response is pending.
   a_write_ready: assert property (@(posedge clk) disable iff (reset)
      awvalid && wvalid && !bvalid |-> awready && wready)
      else stop_on_error("awready or wready stayed low for a write that could be taken");

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle > TIMEOUT_CYCLES)
         stop_on_error("Timeout: the run went past its cycle limit");
   end

   initial begin
      logic [31:0] val;
      logic [1:0]  resp;
      logic        prev_clk;
      logic        fell;
      int          sent;
      reset      = 1'b1;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      exp_wr     = '0;
      rand_state = 32'd47972;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      // Idle after reset.
      @(negedge clk);
      expect_eq("ps2_clk idle", 32'(ps2_clk), 32'd1);
      expect_eq("ps2_data idle", 32'(ps2_data), 32'd1);
      check_status(1'b1, 1'b0, 1'b0, 1'b0, 0);
      axi_read(ADDR_CTRL, val, resp);
      expect_eq("CTRL after reset", val, 32'd0);

      // Unmapped write with bready held low.
      @(negedge clk);
      awaddr  = ADDR_BAD;
      wdata   = 32'd1;
      wstrb   = 4'hF;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b0;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      repeat (5) begin
         expect_eq("bvalid held", 32'(bvalid), 32'd1);
         expect_eq("bresp unmapped", 32'(bresp), 32'(RESP_SLVERR));
         expect_eq("awready while stalled", 32'(awready), 32'd0);
         expect_eq("wready while stalled", 32'(wready), 32'd0);
         @(negedge clk);
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      @(negedge clk);
      expect_eq("bvalid after bready", 32'(bvalid), 32'd0);

      // Unmapped read with rready held low.
      araddr  = ADDR_BAD;
      arvalid = 1'b1;
      rready  = 1'b0;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      repeat (5) begin
         expect_eq("rvalid held", 32'(rvalid), 32'd1);
         expect_eq("rresp unmapped", 32'(rresp), 32'(RESP_SLVERR));
         expect_eq("arready while stalled", 32'(arready), 32'd0);
         @(negedge clk);
      end
      arvalid = 1'b0;
      rready  = 1'b1;
      @(negedge clk);
      expect_eq("rvalid after rready", 32'(rvalid), 32'd0);

      // Single byte and latency to the first PS/2 clock fall.
      axi_write(ADDR_CTRL, 32'd1, resp);
      push_byte(rand_byte());
      prev_clk = ps2_clk;
      fell     = 1'b0;
      while (!fell && cycle - accept_cyc <= 4 * FIRST_FALL_MAX) begin
         @(negedge clk);
         fell     = prev_clk && !ps2_clk;
         prev_clk = ps2_clk;
      end
      assert (fell) else stop_on_error("No falling ps2_clk edge after the first byte");
      assert (cycle - accept_cyc <= FIRST_FALL_MAX)
         else report_mismatch("cycles to first ps2_clk fall, limit", 32'(FIRST_FALL_MAX),
                              32'(cycle - accept_cyc));
      wait_drained();

      // Fill with sending held off, then overflow and clear it.
      axi_write(ADDR_CTRL, 32'd0, resp);
      repeat (FIFO_DEPTH) push_byte(rand_byte());
      check_status(1'b0, 1'b1, 1'b0, 1'b0, FIFO_DEPTH);
      axi_write(ADDR_TXDATA, {24'd0, rand_byte()}, resp);   // Dropped byte.
      expect_eq("bresp on full FIFO", 32'(resp), 32'(RESP_OKAY));
      check_status(1'b0, 1'b1, 1'b0, 1'b1, FIFO_DEPTH);
      axi_write(ADDR_STATUS, 32'd1 << ST_OVERFLOW, resp);
      check_status(1'b0, 1'b1, 1'b0, 1'b0, FIFO_DEPTH);
      axi_write(ADDR_CTRL, 32'd1, resp);
      axi_read(ADDR_STATUS, val, resp);
      expect_eq("STATUS busy while sending", 32'(val[ST_BUSY]), 32'd1);
      wait_drained();

      // Stream with a retry whenever the FIFO is full.
      sent = 0;
      while (sent < STREAM_BYTES) begin
         axi_read(ADDR_STATUS, val, resp);
         if (!val[ST_FULL]) begin
            push_byte(rand_byte());
            sent++;
         end
      end
      wait_drained();
      check_status(1'b1, 1'b0, 1'b0, 1'b0, 0);

      if (rx_total == TOTAL_BYTES) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         stop_on_error($sformatf("Host received %0d bytes but %0d were sent",
                                 rx_total, TOTAL_BYTES));
      end
   end

endmodule
